// File: ldq_cfg_pkg.sv
package ldq_cfg_pkg;

    // queue depth and the id width derived from it
    localparam int LDQ_NUM_ENTRIES = 4;
    localparam int LDQ_ID_W        = $clog2(LDQ_NUM_ENTRIES);

    // reorder-buffer id width
    localparam int ROB_ID_W = 4;

    // word address into the data memory and the width of one load
    localparam int ADDR_W = 5;
    localparam int DATA_W = 16;

    // one load can sit in the dispatch register while stall rises,
    // so one entry is held back for it
    localparam int STALL_MARGIN = 1;

endpackage

// File: ldq_uop_pkg.sv
package ldq_uop_pkg;

    import ldq_cfg_pkg::*;

    localparam int UOP_W         = 32;
    localparam int OP_W          = 4;
    localparam int UOP_PAYLOAD_W = UOP_W - OP_W - ROB_ID_W;
    localparam int UOP_PAD_W     = UOP_PAYLOAD_W - 2 * ADDR_W;

    typedef logic [LDQ_ID_W-1:0] t_ldq_id;
    typedef logic [ROB_ID_W-1:0] t_rob_id;
    typedef logic [ADDR_W-1:0]   t_addr;
    typedef logic [DATA_W-1:0]   t_data;

    typedef enum logic [OP_W-1:0] {
        OP_NOP = 4'h0,
        OP_ALU = 4'h1,
        OP_LD  = 4'h2,
        OP_ST  = 4'h3,
        OP_BR  = 4'h4,
        OP_MUL = 4'h5
    } t_uop_op;

    // load view, only meaningful when op is OP_LD
    typedef struct packed {
        t_uop_op                  op;
        t_rob_id                  robid;
        t_addr                    base;
        logic signed [ADDR_W-1:0] offset;
        logic [UOP_PAD_W-1:0]     pad;
    } t_uop_ld;

    typedef struct packed {
        t_uop_op                  op;
        t_rob_id                  robid;
        logic [UOP_PAYLOAD_W-1:0] payload;
    } t_uop_gen;

    typedef union packed {
        t_uop_ld  ld;
        t_uop_gen gen;
    } t_uop;

endpackage

// File: ldq_dispatch.sv
`timescale 1ns/100ps

module ldq_dispatch
    import ldq_uop_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    disp_valid,
    input  t_uop    disp_uop,
    output logic    disp_ready,
    input  logic    stall,
    input  logic    nuke_valid,
    input  t_rob_id nuke_robid,
    output logic    alloc_valid,
    output t_rob_id alloc_robid,
    output t_addr   alloc_addr,
    input  t_ldq_id ldqid_alloc,
    output logic    out_valid,
    output t_ldq_id ldqid_out
);

    logic    uop_is_ld;
    logic    in_nuked;
    logic    take_ld;
    logic    held_nuked;
    logic    held_q;
    t_rob_id robid_q;
    t_addr   addr_q;
    t_addr   ld_addr;

    assign disp_ready = ~stall;
    assign uop_is_ld  = (disp_uop.gen.op == OP_LD);

    always_comb begin
        ld_addr = '0;
        if (uop_is_ld) begin
            // the sum wraps inside the word address space
            ld_addr = disp_uop.ld.base + t_addr'(disp_uop.ld.offset);
        end
    end

    // non-loads are taken off the input and simply dropped
    assign in_nuked = nuke_valid & (disp_uop.gen.robid >= nuke_robid);
    assign take_ld  = disp_valid & disp_ready & uop_is_ld & ~in_nuked;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_q <= 1'b0;
        end else begin
            held_q <= take_ld;
        end
    end

    always_ff @(posedge clk) begin
        if (take_ld) begin
            robid_q <= disp_uop.gen.robid;
            addr_q  <= ld_addr;
        end
    end

    // a nuke in the allocation cycle keeps the held load out of the queue
    assign held_nuked  = nuke_valid & (robid_q >= nuke_robid);
    assign alloc_valid = held_q & ~held_nuked;
    assign alloc_robid = robid_q;
    assign alloc_addr  = addr_q;

    assign out_valid = alloc_valid;
    assign ldqid_out = ldqid_alloc;

    // back-to-back loads must never be handed the same entry
    a_alloc_id_distinct: assert property (
        @(posedge clk) disable iff (!rst_n)
        alloc_valid |=> !alloc_valid || (ldqid_alloc != $past(ldqid_alloc))
    );

endmodule

// File: loadq_entry.sv
`timescale 1ns/100ps

module loadq_entry
    import ldq_uop_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    alloc,
    input  t_rob_id alloc_robid,
    input  t_addr   alloc_addr,
    input  logic    issue,
    input  logic    gnt,
    input  logic    bus_done,
    input  logic    nuke_valid,
    input  t_rob_id nuke_robid,
    output logic    valid,
    output logic    req,
    output t_rob_id robid,
    output t_addr   addr,
    output logic    killed
);

    logic    valid_q;
    logic    ready_q;
    logic    bus_q;
    logic    killed_q;
    logic    nuke_hit;
    t_rob_id robid_q;
    t_addr   addr_q;

    assign nuke_hit = nuke_valid & valid_q & (robid_q >= nuke_robid);

    // free -> waiting for issue -> ready -> on bus -> free
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= 1'b0;
            ready_q  <= 1'b0;
            bus_q    <= 1'b0;
            killed_q <= 1'b0;
        end else if (alloc) begin
            valid_q  <= 1'b1;
            ready_q  <= 1'b0;
            bus_q    <= 1'b0;
            killed_q <= 1'b0;
        end else if (bus_done) begin
            valid_q  <= 1'b0;
            ready_q  <= 1'b0;
            bus_q    <= 1'b0;
            killed_q <= 1'b0;
        end else if (nuke_hit && !bus_q && !gnt) begin
            valid_q <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            // once the bus is committed, a nuke only silences the completion
            if (nuke_hit) begin
                killed_q <= 1'b1;
            end
            if (issue) begin
                ready_q <= 1'b1;
            end
            if (gnt) begin
                bus_q   <= 1'b1;
                ready_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            robid_q <= alloc_robid;
            addr_q  <= alloc_addr;
        end
    end

    assign valid  = valid_q;
    assign req    = valid_q & ready_q;
    assign robid  = robid_q;
    assign addr   = addr_q;
    assign killed = killed_q;

    a_issue_to_valid: assert property (
        @(posedge clk) disable iff (!rst_n) issue |-> valid_q
    );

endmodule

// File: loadq.sv
`timescale 1ns/100ps

module loadq
    import ldq_cfg_pkg::*, ldq_uop_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    alloc_valid,
    input  t_rob_id alloc_robid,
    input  t_addr   alloc_addr,
    output t_ldq_id ldqid_alloc,
    output logic    stall,
    input  logic    iss_valid,
    input  t_ldq_id iss_ldqid,
    input  logic    nuke_valid,
    input  t_rob_id nuke_robid,
    output logic    cyc,
    output logic    stb,
    output logic    we,
    output t_addr   adr,
    input  logic    ack,
    input  t_data   dat,
    output logic    ld_done,
    output t_rob_id ld_done_robid,
    output t_data   ld_done_data,
    output logic    idle,
    output logic    full
);

    logic [LDQ_NUM_ENTRIES-1:0] e_valid;
    logic [LDQ_NUM_ENTRIES-1:0] e_req;
    logic [LDQ_NUM_ENTRIES-1:0] e_alloc;
    logic [LDQ_NUM_ENTRIES-1:0] e_issue;
    logic [LDQ_NUM_ENTRIES-1:0] e_gnt;
    logic [LDQ_NUM_ENTRIES-1:0] e_done;
    logic [LDQ_NUM_ENTRIES-1:0] e_killed;
    t_rob_id                    e_robid [LDQ_NUM_ENTRIES];
    t_addr                      e_addr  [LDQ_NUM_ENTRIES];
    t_ldq_id                    win_id;
    t_ldq_id                    cur_q;
    logic                       busy_q;
    logic                       grant;
    logic                       cur_nuked;

    // lowest free index and lowest requesting index
    always_comb begin
        ldqid_alloc = '0;
        win_id      = '0;
        for (int i = LDQ_NUM_ENTRIES - 1; i >= 0; i--) begin
            if (!e_valid[i]) begin
                ldqid_alloc = t_ldq_id'(i);
            end
            if (e_req[i]) begin
                win_id = t_ldq_id'(i);
            end
        end
    end

    assign grant = ~busy_q & (|e_req);

    always_comb begin
        for (int i = 0; i < LDQ_NUM_ENTRIES; i++) begin
            e_alloc[i] = alloc_valid & (ldqid_alloc == t_ldq_id'(i));
            e_issue[i] = iss_valid & (iss_ldqid == t_ldq_id'(i));
            e_gnt[i]   = grant & (win_id == t_ldq_id'(i));
            e_done[i]  = busy_q & ack & (cur_q == t_ldq_id'(i));
        end
    end

    for (genvar e = 0; e < LDQ_NUM_ENTRIES; e++) begin : g_entry
        loadq_entry i_entry (
            .clk         (clk),
            .rst_n       (rst_n),
            .alloc       (e_alloc[e]),
            .alloc_robid (alloc_robid),
            .alloc_addr  (alloc_addr),
            .issue       (e_issue[e]),
            .gnt         (e_gnt[e]),
            .bus_done    (e_done[e]),
            .nuke_valid  (nuke_valid),
            .nuke_robid  (nuke_robid),
            .valid       (e_valid[e]),
            .req         (e_req[e]),
            .robid       (e_robid[e]),
            .addr        (e_addr[e]),
            .killed      (e_killed[e])
        );
    end

    // the winner's index is held for the whole transfer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            cur_q  <= '0;
        end else if (grant) begin
            busy_q <= 1'b1;
            cur_q  <= win_id;
        end else if (ack) begin
            busy_q <= 1'b0;
        end
    end

    assign cyc = busy_q;
    assign stb = busy_q;
    assign we  = 1'b0;
    assign adr = e_addr[cur_q];

    // a nuke landing in the ack cycle also silences the completion
    assign cur_nuked = e_killed[cur_q] | (nuke_valid & (e_robid[cur_q] >= nuke_robid));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_done <= 1'b0;
            stall   <= 1'b0;
        end else begin
            ld_done <= busy_q & ack & ~cur_nuked;
            stall   <= ($countones(e_valid) + int'(alloc_valid))
                       >= (LDQ_NUM_ENTRIES - STALL_MARGIN);
        end
    end

    always_ff @(posedge clk) begin
        if (busy_q && ack) begin
            ld_done_robid <= e_robid[cur_q];
            ld_done_data  <= dat;
        end
    end

    assign idle = ~|e_valid;
    assign full = &e_valid;

    a_wb_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (stb && !ack) |=> (cyc && stb && $stable(adr))
    );

    a_no_alloc_full: assert property (
        @(posedge clk) disable iff (!rst_n) alloc_valid |-> !full
    );

endmodule

// File: ld_data_mem.sv
`timescale 1ns/100ps

module ld_data_mem
    import ldq_cfg_pkg::*, ldq_uop_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  cyc,
    input  logic  stb,
    input  logic  we,
    input  t_addr adr,
    output logic  ack,
    output t_data dat
);

    t_data      mem [0:2**ADDR_W-1];
    logic [1:0] wait_q;
    logic       access;
    logic       wait_over;

    initial begin
        $readmemh("mem_init.hex", mem);
    end

    // writes are not supported, so a write strobe is never acknowledged
    assign access    = cyc & stb & ~we & ~ack;
    assign wait_over = (wait_q == adr[1:0]);

    // the low two address bits choose between one and four wait cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack    <= 1'b0;
            wait_q <= '0;
        end else begin
            ack <= 1'b0;
            if (access) begin
                if (wait_over) begin
                    ack    <= 1'b1;
                    wait_q <= '0;
                end else begin
                    wait_q <= wait_q + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access && wait_over) begin
            dat <= mem[adr];
        end
    end

    a_ack_in_strobe: assert property (
        @(posedge clk) disable iff (!rst_n) ack |-> stb
    );

endmodule

// File: ldq_subsys.sv
`timescale 1ns/100ps

module ldq_subsys
    import ldq_uop_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    disp_valid,
    input  t_uop    disp_uop,
    output logic    disp_ready,
    output logic    out_valid,
    output t_ldq_id ldqid_out,
    input  logic    iss_valid,
    input  t_ldq_id iss_ldqid,
    input  logic    nuke_valid,
    input  t_rob_id nuke_robid,
    output logic    ld_done,
    output t_rob_id ld_done_robid,
    output t_data   ld_done_data,
    output logic    idle,
    output logic    full
);

    logic    stall;
    logic    alloc_valid;
    t_rob_id alloc_robid;
    t_addr   alloc_addr;
    t_ldq_id ldqid_alloc;
    logic    cyc;
    logic    stb;
    logic    we;
    t_addr   adr;
    logic    ack;
    t_data   dat;

    ldq_dispatch i_dispatch (
        .clk         (clk),
        .rst_n       (rst_n),
        .disp_valid  (disp_valid),
        .disp_uop    (disp_uop),
        .disp_ready  (disp_ready),
        .stall       (stall),
        .nuke_valid  (nuke_valid),
        .nuke_robid  (nuke_robid),
        .alloc_valid (alloc_valid),
        .alloc_robid (alloc_robid),
        .alloc_addr  (alloc_addr),
        .ldqid_alloc (ldqid_alloc),
        .out_valid   (out_valid),
        .ldqid_out   (ldqid_out)
    );

    loadq i_loadq (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc_valid   (alloc_valid),
        .alloc_robid   (alloc_robid),
        .alloc_addr    (alloc_addr),
        .ldqid_alloc   (ldqid_alloc),
        .stall         (stall),
        .iss_valid     (iss_valid),
        .iss_ldqid     (iss_ldqid),
        .nuke_valid    (nuke_valid),
        .nuke_robid    (nuke_robid),
        .cyc           (cyc),
        .stb           (stb),
        .we            (we),
        .adr           (adr),
        .ack           (ack),
        .dat           (dat),
        .ld_done       (ld_done),
        .ld_done_robid (ld_done_robid),
        .ld_done_data  (ld_done_data),
        .idle          (idle),
        .full          (full)
    );

    ld_data_mem i_data_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .ack   (ack),
        .dat   (dat)
    );

endmodule

// File: tb_ldq_subsys.sv
`timescale 1ns/100ps

module tb_ldq_subsys
    import ldq_cfg_pkg::*, ldq_uop_pkg::*;
;

    localparam int CLK_PERIOD = 100;
    localparam int K_DISP     = 0;
    localparam int K_ISSUE    = 1;
    localparam int K_NUKE     = 2;
    localparam int K_IDLE     = 3;
    localparam int K_FLAGS    = 4;
    localparam int NUM_ROB    = 2**ROB_ID_W;

    typedef struct {
        int kind;
        bit is_ld;
        bit rnd_off;
        int robid;
        int base;
        int exp;
    } step_t;

    logic    clk;
    logic    rst_n;
    logic    disp_valid;
    t_uop    disp_uop;
    logic    disp_ready;
    logic    out_valid;
    t_ldq_id ldqid_out;
    logic    iss_valid;
    t_ldq_id iss_ldqid;
    logic    nuke_valid;
    t_rob_id nuke_robid;
    logic    ld_done;
    t_rob_id ld_done_robid;
    t_data   ld_done_data;
    logic    idle;
    logic    full;

    step_t steps[$];
    t_data model [0:2**ADDR_W-1];
    logic  pending [NUM_ROB];
    logic  killed [NUM_ROB];
    t_addr exp_addr [NUM_ROB];
    int    seed = 32'h283f62d1;
    int    errors = 0;
    int    table_len = 0;

    ldq_subsys i_ldq_subsys (
        .clk           (clk),
        .rst_n         (rst_n),
        .disp_valid    (disp_valid),
        .disp_uop      (disp_uop),
        .disp_ready    (disp_ready),
        .out_valid     (out_valid),
        .ldqid_out     (ldqid_out),
        .iss_valid     (iss_valid),
        .iss_ldqid     (iss_ldqid),
        .nuke_valid    (nuke_valid),
        .nuke_robid    (nuke_robid),
        .ld_done       (ld_done),
        .ld_done_robid (ld_done_robid),
        .ld_done_data  (ld_done_data),
        .idle          (idle),
        .full          (full)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic add_step(input int kind, input bit is_ld, input bit rnd_off,
                            input int robid, input int base, input int exp);
        step_t s;
        s.kind    = kind;
        s.is_ld   = is_ld;
        s.rnd_off = rnd_off;
        s.robid   = robid;
        s.base    = base;
        s.exp     = exp;
        steps.push_back(s);
    endtask

    task automatic check_ldqid(input t_ldq_id got, input t_ldq_id exp);
        if (got !== exp) begin
            $display("Error at %0t: ldqid_out is %0d, expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_result(input t_rob_id robid, input t_data got);
        if (!pending[robid]) begin
            $display("Error at %0t: ld_done for robid %0d, which is not outstanding",
                     $time, robid);
            errors++;
        end else if (killed[robid]) begin
            $display("Error at %0t: ld_done for killed robid %0d", $time, robid);
            errors++;
        end else begin
            if (got !== model[exp_addr[robid]]) begin
                $display("Error at %0t: robid %0d data %h, expected %h", $time, robid,
                         got, model[exp_addr[robid]]);
                errors++;
            end
            pending[robid] = 1'b0;
        end
    endtask

    task automatic check_flags(input logic ready, input logic is_full, input logic is_idle,
                               input logic [2:0] exp);
        if ({ready, is_full, is_idle} !== exp) begin
            $display("Error at %0t: ready/full/idle are %b%b%b, expected %b", $time,
                     ready, is_full, is_idle, exp);
            errors++;
        end
    endtask

    // completions may come back in any order, so each one is matched by robid
    always @(negedge clk) begin
        if (rst_n && ld_done) begin
            check_result(ld_done_robid, ld_done_data);
        end
    end

    task automatic run_dispatch(input step_t s);
        t_uop u;
        int   off;
        while (!disp_ready) @(negedge clk);
        u = '0;
        if (s.is_ld) begin
            off = s.rnd_off ? ($random(seed) % 16) : 0;
            u.ld.op     = OP_LD;
            u.ld.robid  = t_rob_id'(s.robid);
            u.ld.base   = t_addr'(s.base);
            u.ld.offset = t_addr'(off);
            pending[s.robid]  = 1'b1;
            killed[s.robid]   = 1'b0;
            exp_addr[s.robid] = t_addr'((s.base + off + 32) % 32);
        end else begin
            u.gen.op      = t_uop_op'(({$random(seed)} % 2) ? OP_ST : OP_ALU);
            u.gen.robid   = t_rob_id'(s.robid);
            u.gen.payload = UOP_PAYLOAD_W'($random(seed));
        end
        disp_valid = 1'b1;
        disp_uop   = u;
        @(negedge clk);
        disp_valid = 1'b0;
        if (s.is_ld && !out_valid) begin
            $display("Error at %0t: no out_valid for load robid %0d", $time, s.robid);
            errors++;
        end else if (s.is_ld) begin
            check_ldqid(ldqid_out, t_ldq_id'(s.exp));
        end else if (out_valid) begin
            $display("Error at %0t: out_valid raised for a non-load", $time);
            errors++;
        end
    endtask

    task automatic run_step(input step_t s);
        case (s.kind)
            K_DISP: run_dispatch(s);
            K_ISSUE: begin
                // one spare cycle lets a just-allocated entry become valid
                @(negedge clk);
                iss_valid = 1'b1;
                iss_ldqid = t_ldq_id'(s.exp);
                @(negedge clk);
                iss_valid = 1'b0;
            end
            K_NUKE: begin
                for (int r = 0; r < NUM_ROB; r++) begin
                    if (pending[r] && r >= s.robid) killed[r] = 1'b1;
                end
                nuke_valid = 1'b1;
                nuke_robid = t_rob_id'(s.robid);
                @(negedge clk);
                nuke_valid = 1'b0;
            end
            K_IDLE: begin
                while (!idle) @(negedge clk);
                @(negedge clk);
                for (int r = 0; r < NUM_ROB; r++) begin
                    if (pending[r] && !killed[r]) begin
                        $display("Load with robid %0d never completed", r);
                        errors++;
                    end
                    pending[r] = 1'b0;
                end
            end
            default: begin
                @(negedge clk);
                check_flags(disp_ready, full, idle, s.exp[2:0]);
            end
        endcase
    endtask

    initial begin
        int err_before;
        rst_n      = 1'b0;
        disp_valid = 1'b0;
        disp_uop   = '0;
        iss_valid  = 1'b0;
        iss_ldqid  = '0;
        nuke_valid = 1'b0;
        nuke_robid = '0;
        for (int r = 0; r < NUM_ROB; r++) begin
            pending[r] = 1'b0;
            killed[r]  = 1'b0;
        end
        $readmemh("mem_init.hex", model);

        // allocation order, non-load drop, stall at three and reuse of entry 0
        add_step(K_DISP, 1, 1, 1, 3, 0);
        add_step(K_DISP, 0, 0, 0, 0, 0);
        add_step(K_DISP, 1, 1, 2, 10, 1);
        add_step(K_DISP, 1, 1, 3, 17, 2);
        add_step(K_FLAGS, 0, 0, 0, 0, 3'b000);
        add_step(K_ISSUE, 0, 0, 0, 0, 0);
        add_step(K_DISP, 1, 1, 4, 21, 0);
        add_step(K_ISSUE, 0, 0, 0, 0, 1);
        add_step(K_ISSUE, 0, 0, 0, 0, 2);
        add_step(K_ISSUE, 0, 0, 0, 0, 0);
        add_step(K_IDLE, 0, 0, 0, 0, 0);
        // four loads back to back fill the queue
        add_step(K_DISP, 1, 1, 5, 6, 0);
        add_step(K_DISP, 1, 1, 6, 13, 1);
        add_step(K_DISP, 1, 1, 7, 26, 2);
        add_step(K_DISP, 1, 1, 8, 31, 3);
        add_step(K_FLAGS, 0, 0, 0, 0, 3'b010);
        for (int i = 0; i < 4; i++) add_step(K_ISSUE, 0, 0, 0, 0, i);
        add_step(K_IDLE, 0, 0, 0, 0, 0);
        // robid 10 sits on the bus at a slow address when the nuke lands
        add_step(K_DISP, 1, 0, 9, 4, 0);
        add_step(K_DISP, 1, 0, 10, 7, 1);
        add_step(K_DISP, 1, 1, 11, 20, 2);
        add_step(K_ISSUE, 0, 0, 0, 0, 1);
        add_step(K_NUKE, 0, 0, 10, 0, 0);
        add_step(K_ISSUE, 0, 0, 0, 0, 0);
        add_step(K_IDLE, 0, 0, 0, 0, 0);
        add_step(K_FLAGS, 0, 0, 0, 0, 3'b101);
        table_len = steps.size();

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < steps.size(); i++) begin
            err_before = errors;
            run_step(steps[i]);
            $display("step %0d kind %0d: %s", i, steps[i].kind,
                     (errors == err_before) ? "ok" : "failed");
        end
        $display("steps run %0d, errors %0d", steps.size(), errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        wait (table_len != 0);
        #((table_len * 40 + 8) * CLK_PERIOD);
        $display("The run hung and was stopped by the watchdog");
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: mem_init.hex
// one 16-bit data word per line, word address 0 to 31 in order
40ff
41fe
42fd
43fc
44fb
45fa
46f9
47f8
48f7
49f6
4af5
4bf4
4cf3
4df2
4ef1
4ff0
50ef
51ee
52ed
53ec
54eb
55ea
56e9
57e8
58e7
59e6
5ae5
5be4
5ce3
5de2
5ee1
5fe0

// File: vlog.f
ldq_cfg_pkg.sv
ldq_uop_pkg.sv
ldq_dispatch.sv
loadq_entry.sv
loadq.sv
ld_data_mem.sv
ldq_subsys.sv
tb_ldq_subsys.sv
